// File: hdl/pi_pkg.sv
package pi_pkg;

	// delay units, one mixer enable each
	localparam int unsigned N_UNIT = 32;

	// qperi, max_sel_mux and the coarse phase number
	localparam int unsigned UNIT_W = 5;

	// fine blend bits at the bottom of the phase code
	localparam int unsigned N_BLENDER = 4;

	localparam int unsigned CODE_W = UNIT_W + N_BLENDER;

	// even/odd phase number into the two mux stages
	localparam int unsigned PH_W = 4;

	// complete control word for the analog PI
	typedef struct packed {
		logic [3:0][1:0]             mux_1st_even;
		logic [3:0][1:0]             mux_1st_odd;
		logic [1:0]                  mux_2nd_even;
		logic [1:0]                  mux_2nd_odd;
		logic [2**N_BLENDER-1:0]     thm_sel_bld;
	} pi_sel_t;

	// software override of the quarter period
	typedef struct packed {
		logic              en;
		logic [UNIT_W-1:0] val;
	} ext_qperi_t;

	// accumulator command, decoded from the loop strobes
	typedef enum logic [1:0] {
		CMD_HOLD,
		CMD_UP,
		CMD_DN,
		CMD_LOAD
	} acc_cmd_e;

endpackage

// File: hdl/arb_filter.sv
`timescale 1ns/100ps

module arb_filter #(
	parameter int unsigned FILT_LEN = 4
) (
	input  logic                      clk_cdr,
	input  logic                      rstb,
	input  logic [pi_pkg::N_UNIT-1:0] arb_out,
	output logic [pi_pkg::N_UNIT-1:0] arb_held
);

	localparam int unsigned CNT_W = $clog2(FILT_LEN + 1);

	// two-flop synchronizer
	logic [pi_pkg::N_UNIT-1:0] arb_meta;
	logic [pi_pkg::N_UNIT-1:0] arb_sync;

	// synchronized word from the previous edge
	logic [pi_pkg::N_UNIT-1:0] arb_prev;

	logic [CNT_W-1:0] stable_cnt;
	logic [CNT_W-1:0] stable_nxt;

	always_ff @(posedge clk_cdr or negedge rstb) begin
		if (!rstb) begin
			arb_meta <= '0;
			arb_sync <= '0;
		end else begin
			arb_meta <= arb_out;
			arb_sync <= arb_meta;
		end
	end

	// count of consecutive edges that have seen the current synchronized word,
	// including this one; saturates at FILT_LEN
	always_comb begin
		if (arb_sync != arb_prev) begin
			stable_nxt = CNT_W'(1);
		end else if (stable_cnt == CNT_W'(FILT_LEN)) begin
			stable_nxt = stable_cnt;
		end else begin
			stable_nxt = stable_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk_cdr or negedge rstb) begin
		if (!rstb) begin
			arb_prev   <= '0;
			stable_cnt <= '0;
		end else begin
			arb_prev   <= arb_sync;
			stable_cnt <= stable_nxt;
		end
	end

	// held word moves only once the new value has settled;
	// shorter excursions restart the count and never get here
	always_ff @(posedge clk_cdr or negedge rstb) begin
		if (!rstb) begin
			arb_held <= '0;
		end else if (stable_nxt == CNT_W'(FILT_LEN)) begin
			arb_held <= arb_sync;
		end
	end

endmodule

// File: hdl/phase_accum.sv
`timescale 1ns/100ps

module phase_accum #(
	parameter int unsigned STEP_W = 4
) (
	input  logic                      clk_cdr,
	input  logic                      rstb,
	input  logic                      up,
	input  logic                      dn,
	input  logic                      load,
	input  logic [STEP_W-1:0]         step,
	input  logic [pi_pkg::CODE_W-1:0] load_code,
	input  logic [pi_pkg::UNIT_W-1:0] max_sel_mux,
	output logic [pi_pkg::CODE_W-1:0] ctl
);

	// one spare bit so the period length (up to 512) fits
	localparam int unsigned PER_W = pi_pkg::CODE_W + 1;

	pi_pkg::acc_cmd_e cmd;

	logic [pi_pkg::UNIT_W:0]   per_units;
	logic [PER_W-1:0]          per_len;
	logic [PER_W-1:0]          code_ext;
	logic [PER_W-1:0]          step_ext;
	logic [PER_W-1:0]          sum_up;
	logic [PER_W-1:0]          sum_dn;
	logic [pi_pkg::UNIT_W-1:0] ld_phase;
	logic [pi_pkg::CODE_W-1:0] code_nxt;

	// load wins, opposing strobes cancel
	always_comb begin
		if (load) begin
			cmd = pi_pkg::CMD_LOAD;
		end else if (up && !dn) begin
			cmd = pi_pkg::CMD_UP;
		end else if (dn && !up) begin
			cmd = pi_pkg::CMD_DN;
		end else begin
			cmd = pi_pkg::CMD_HOLD;
		end
	end

	// period is max_sel_mux+1 units of 16 codes
	assign per_units = {1'b0, max_sel_mux} + (pi_pkg::UNIT_W + 1)'(1);
	assign per_len   = {per_units, {pi_pkg::N_BLENDER{1'b0}}};
	assign code_ext  = {1'b0, ctl};
	assign step_ext  = PER_W'(step);

	always_comb begin
		sum_up = code_ext + step_ext;
		if (sum_up >= per_len) begin
			sum_up = sum_up - per_len;
		end
		// borrow from the period on underflow
		if (code_ext >= step_ext) begin
			sum_dn = code_ext - step_ext;
		end else begin
			sum_dn = code_ext + per_len - step_ext;
		end
	end

	// blend bits are below one unit, only the coarse phase needs folding
	assign ld_phase = pi_pkg::UNIT_W'(load_code[pi_pkg::CODE_W-1:pi_pkg::N_BLENDER] % per_units);

	always_comb begin
		case (cmd)
			pi_pkg::CMD_UP:   code_nxt = sum_up[pi_pkg::CODE_W-1:0];
			pi_pkg::CMD_DN:   code_nxt = sum_dn[pi_pkg::CODE_W-1:0];
			pi_pkg::CMD_LOAD: code_nxt = {ld_phase, load_code[pi_pkg::N_BLENDER-1:0]};
			default:          code_nxt = ctl;
		endcase
	end

	always_ff @(posedge clk_cdr or negedge rstb) begin
		if (!rstb) begin
			ctl <= '0;
		end else begin
			ctl <= code_nxt;
		end
	end

endmodule

// File: hdl/pi_local_encoder.sv
`timescale 1ns/100ps

module pi_local_encoder (
	input  logic                      clk_cdr,
	input  logic                      rstb,
	input  logic [pi_pkg::CODE_W-1:0] ctl,
	input  logic [pi_pkg::N_UNIT-1:0] arb_out,
	input  pi_pkg::ext_qperi_t        ext_qperi,
	output pi_pkg::pi_sel_t           sel,
	output logic [pi_pkg::UNIT_W-1:0] qperi,
	output logic [pi_pkg::UNIT_W-1:0] max_sel_mux,
	output logic [pi_pkg::N_UNIT-1:0] en_mixer
);

	localparam int unsigned N_THM = 2**pi_pkg::N_BLENDER;
	localparam logic [N_THM-1:0] THM_ONES = '1;

	logic [pi_pkg::UNIT_W-1:0]    int_qperi;
	logic [pi_pkg::UNIT_W-1:0]    phase;
	logic [pi_pkg::N_BLENDER-1:0] blend;
	logic [pi_pkg::UNIT_W:0]      phase_inc;
	logic [pi_pkg::N_BLENDER:0]   blend_inc;

	logic [pi_pkg::PH_W-1:0] ph_even_d;
	logic [pi_pkg::PH_W-1:0] ph_odd_d;
	logic [N_THM-1:0]        thm_d;

	logic [pi_pkg::PH_W-1:0] ph_num_even;
	logic [pi_pkg::PH_W-1:0] ph_num_odd;
	logic [N_THM-1:0]        thm_q;

	// first-stage mux k; parks at 3 or 0 when the number lives in another group,
	// so the unused mux sits next to the boundary for a clean handover
	function automatic logic [1:0] first_sel(input logic [pi_pkg::PH_W-1:0] num,
		input int k);
		logic [1:0] res;
		if (num[pi_pkg::PH_W-1:2] == 2'(k)) begin
			res = num[1:0];
		end else if ({1'b0, num} == (pi_pkg::PH_W + 1)'(4 * (k + 1))) begin
			res = 2'd3;
		end else begin
			res = 2'd0;
		end
		return res;
	endfunction

	// quarter period from the first 1-to-0 step in the arbiter word
	always_comb begin
		int_qperi = pi_pkg::UNIT_W'(pi_pkg::N_UNIT - 1);
		// walk down so the lowest match is the one kept
		for (int i = pi_pkg::N_UNIT - 1; i >= 1; i--) begin
			if (arb_out[i-1] && !arb_out[i]) begin
				int_qperi = pi_pkg::UNIT_W'(i);
			end
		end
	end

	assign qperi = ext_qperi.en ? ext_qperi.val : int_qperi;

	// highest mux code in use is always odd
	assign max_sel_mux = qperi[0] ? qperi : qperi - pi_pkg::UNIT_W'(1);
	assign en_mixer    = pi_pkg::N_UNIT'(1) << max_sel_mux;

	assign phase     = ctl[pi_pkg::CODE_W-1:pi_pkg::N_BLENDER];
	assign blend     = ctl[pi_pkg::N_BLENDER-1:0];
	assign phase_inc = {1'b0, phase} + (pi_pkg::UNIT_W + 1)'(1);
	assign blend_inc = {1'b0, blend} + (pi_pkg::N_BLENDER + 1)'(1);

	// even path wraps back to 0 at the top of the period
	assign ph_even_d = (phase == max_sel_mux) ? '0 : phase_inc[pi_pkg::PH_W:1];
	assign ph_odd_d  = phase[pi_pkg::PH_W:1];

	// even phase fills up with blend, odd phase drains
	assign thm_d = phase[0] ? (THM_ONES >> blend_inc) : (THM_ONES >> (~blend));

	always_ff @(posedge clk_cdr or negedge rstb) begin
		if (!rstb) begin
			ph_num_even <= '0;
			ph_num_odd  <= '0;
			thm_q       <= '0;
		end else begin
			ph_num_even <= ph_even_d;
			ph_num_odd  <= ph_odd_d;
			thm_q       <= thm_d;
		end
	end

	always_comb begin
		sel = '0;
		for (int k = 0; k < 4; k++) begin
			sel.mux_1st_even[k] = first_sel(ph_num_even, k);
			sel.mux_1st_odd[k]  = first_sel(ph_num_odd, k);
		end
		// second stage picks the group
		sel.mux_2nd_even = ph_num_even[pi_pkg::PH_W-1:2];
		sel.mux_2nd_odd  = ph_num_odd[pi_pkg::PH_W-1:2];
		sel.thm_sel_bld  = thm_q;
	end

endmodule

// File: hdl/pi_ctrl_top.sv
`timescale 1ns/100ps

module pi_ctrl_top #(
	parameter int unsigned FILT_LEN = 4,
	parameter int unsigned STEP_W   = 4
) (
	input  logic                      clk_cdr,
	input  logic                      rstb,
	input  logic [pi_pkg::N_UNIT-1:0] arb_out,
	input  logic                      up,
	input  logic                      dn,
	input  logic [STEP_W-1:0]         step,
	input  logic                      load,
	input  logic [pi_pkg::CODE_W-1:0] load_code,
	input  pi_pkg::ext_qperi_t        ext_qperi,
	output pi_pkg::pi_sel_t           sel,
	output logic [pi_pkg::UNIT_W-1:0] qperi,
	output logic [pi_pkg::UNIT_W-1:0] max_sel_mux,
	output logic [pi_pkg::N_UNIT-1:0] en_mixer,
	output logic [pi_pkg::CODE_W-1:0] pi_code
);

	// filtered arbiter word into the encoder
	logic [pi_pkg::N_UNIT-1:0] arb_held;

	arb_filter #(
		.FILT_LEN (FILT_LEN)
	) arb_filter_i (
		.clk_cdr  (clk_cdr),
		.rstb     (rstb),
		.arb_out  (arb_out),
		.arb_held (arb_held)
	);

	// wrap uses max_sel_mux from the encoder
	phase_accum #(
		.STEP_W (STEP_W)
	) phase_accum_i (
		.clk_cdr     (clk_cdr),
		.rstb        (rstb),
		.up          (up),
		.dn          (dn),
		.load        (load),
		.step        (step),
		.load_code   (load_code),
		.max_sel_mux (max_sel_mux),
		.ctl         (pi_code)
	);

	pi_local_encoder pi_local_encoder_i (
		.clk_cdr     (clk_cdr),
		.rstb        (rstb),
		.ctl         (pi_code),
		.arb_out     (arb_held),
		.ext_qperi   (ext_qperi),
		.sel         (sel),
		.qperi       (qperi),
		.max_sel_mux (max_sel_mux),
		.en_mixer    (en_mixer)
	);

endmodule

// File: bench/tb_pi_ctrl.sv
`timescale 1ns/100ps

module tb_pi_ctrl;

	localparam int FILT_LEN     = 4;
	localparam int STEP_W       = 4;
	localparam int N_RAND_STEPS = 24;
	localparam int N_ENC        = 10;

	// cycles spent by each test, summed for the watchdog
	localparam int RESET_CYC = 16 + 2;
	localparam int QP_CYC    = 8 * (FILT_LEN + 4) + 12;
	localparam int FILT_CYC  = FILT_LEN * (2 * FILT_LEN + 4);
	localparam int ACC_CYC   = 2 * (N_RAND_STEPS + 10);
	localparam int ENC_CYC   = 2 * (N_ENC + 8);
	localparam int BUDGET    = RESET_CYC + QP_CYC + FILT_CYC + ACC_CYC + ENC_CYC;
	localparam int MARGIN    = 64;

	logic                      clk_cdr;
	logic                      rstb;
	logic [pi_pkg::N_UNIT-1:0] arb_out;
	logic                      up;
	logic                      dn;
	logic [STEP_W-1:0]         step;
	logic                      load;
	logic [pi_pkg::CODE_W-1:0] load_code;
	pi_pkg::ext_qperi_t        ext_qperi;
	pi_pkg::pi_sel_t           sel;
	logic [pi_pkg::UNIT_W-1:0] qperi;
	logic [pi_pkg::UNIT_W-1:0] max_sel_mux;
	logic [pi_pkg::N_UNIT-1:0] en_mixer;
	logic [pi_pkg::CODE_W-1:0] pi_code;

	// expected phase code and period length of the accumulator
	int exp_code;
	int cur_period;

	pi_ctrl_top #(
		.FILT_LEN (FILT_LEN),
		.STEP_W   (STEP_W)
	) pi_ctrl_top_i (
		.clk_cdr     (clk_cdr),
		.rstb        (rstb),
		.arb_out     (arb_out),
		.up          (up),
		.dn          (dn),
		.step        (step),
		.load        (load),
		.load_code   (load_code),
		.ext_qperi   (ext_qperi),
		.sel         (sel),
		.qperi       (qperi),
		.max_sel_mux (max_sel_mux),
		.en_mixer    (en_mixer),
		.pi_code     (pi_code)
	);

	initial begin
		clk_cdr = 1'b0;
		forever begin
			#10 clk_cdr = ~clk_cdr;
		end
	end

	initial begin
		repeat (BUDGET + MARGIN) @(posedge clk_cdr);
		$display("timeout: tests still running after %0d clock cycles", BUDGET + MARGIN);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// lowest i from 1 upward with bit i-1 set and bit i clear
	function automatic int quarter_period(input logic [pi_pkg::N_UNIT-1:0] arb);
		int q;
		q = -1;
		for (int i = 1; i < pi_pkg::N_UNIT; i++) begin
			if (q < 0 && arb[i-1] && !arb[i]) begin
				q = i;
			end
		end
		if (q < 0) begin
			q = pi_pkg::N_UNIT - 1;
		end
		return q;
	endfunction

	function automatic int max_sel_of(input int q);
		return (q % 2 == 1) ? q : q - 1;
	endfunction

	function automatic int codes_per_period(input int msm);
		return (msm + 1) * 16;
	endfunction

	function automatic int first_stage(input int num, input int k);
		if (num / 4 == k) begin
			return num % 4;
		end else if (num == 4 * (k + 1)) begin
			return 3;
		end
		return 0;
	endfunction

	function automatic pi_pkg::pi_sel_t expected_sel(input int code, input int msm);
		pi_pkg::pi_sel_t s;
		int phase;
		int blend;
		int ev;
		int od;
		int n_ones;
		phase = code / 16;
		blend = code % 16;
		ev = (phase == msm) ? 0 : (phase + 1) / 2;
		od = phase / 2;
		n_ones = (phase % 2 == 0) ? blend + 1 : 15 - blend;
		s = '0;
		for (int k = 0; k < 4; k++) begin
			s.mux_1st_even[k] = 2'(first_stage(ev, k));
			s.mux_1st_odd[k]  = 2'(first_stage(od, k));
		end
		s.mux_2nd_even = 2'(ev / 4);
		s.mux_2nd_odd  = 2'(od / 4);
		s.thm_sel_bld  = 16'((1 << n_ones) - 1);
		return s;
	endfunction

	task automatic period_outputs(input int q, input string what);
		int msm;
		msm = max_sel_of(q);
		compare(64'(qperi), 64'(q), {what, ": qperi"});
		compare(64'(max_sel_mux), 64'(msm), {what, ": max_sel_mux"});
		compare(64'(en_mixer), 64'(1) << msm, {what, ": en_mixer"});
	endtask

	task automatic set_override(input logic en_v, input int val_v);
		ext_qperi.en  = en_v;
		ext_qperi.val = pi_pkg::UNIT_W'(val_v);
	endtask

	// one-cycle strobe, pi_code checked one edge later
	task automatic apply_strobe(input logic up_v, input logic dn_v, input logic load_v,
		input int step_v, input int code_v);
		@(negedge clk_cdr);
		up        = up_v;
		dn        = dn_v;
		load      = load_v;
		step      = STEP_W'(step_v);
		load_code = pi_pkg::CODE_W'(code_v);
		if (load_v) begin
			exp_code = code_v % cur_period;
		end else if (up_v && !dn_v) begin
			exp_code = (exp_code + step_v) % cur_period;
		end else if (dn_v && !up_v) begin
			exp_code = (exp_code + cur_period - step_v) % cur_period;
		end
		@(negedge clk_cdr);
		up   = 1'b0;
		dn   = 1'b0;
		load = 1'b0;
		compare(64'(pi_code), 64'(exp_code), $sformatf(
			"pi_code after up=%0b dn=%0b load=%0b step=%0d code=%0d",
			up_v, dn_v, load_v, step_v, code_v));
	endtask

	// checked while rstb is still low
	task automatic reset_values();
		compare(64'(pi_code), 64'd0, "pi_code in reset");
		compare(64'(sel), 64'd0, "sel in reset");
		period_outputs(quarter_period('0), "reset");
	endtask

	task automatic detect_quarter_period();
		logic [31:0] words [8] = '{32'h0000_0007, 32'h0000_00FF, 32'h0000_1FFF,
			32'h0FF0_FF00, 32'h00FF_FFFF, 32'hFFFF_FFFF, 32'h3FFF_FFFF, 32'h0000_FFFF};
		for (int w = 0; w < 8; w++) begin
			@(negedge clk_cdr);
			arb_out = words[w];
			repeat (FILT_LEN + 3) @(negedge clk_cdr);
			period_outputs(quarter_period(words[w]), $sformatf("arbiter 0x%h", words[w]));
		end
		// override acts within the same cycle
		@(negedge clk_cdr);
		set_override(1'b1, 12);
		#1;
		period_outputs(12, "override 12");
		@(negedge clk_cdr);
		set_override(1'b1, 7);
		#1;
		period_outputs(7, "override 7");
		@(negedge clk_cdr);
		set_override(1'b0, 0);
		#1;
		period_outputs(quarter_period(arb_out), "override off");
	endtask

	task automatic reject_glitch();
		logic [pi_pkg::N_UNIT-1:0] steady;
		int q_before;
		steady = arb_out;
		q_before = quarter_period(steady);
		for (int len = 1; len < FILT_LEN; len++) begin
			@(negedge clk_cdr);
			arb_out = 32'h0000_00FF;
			for (int c = 0; c < len; c++) begin
				@(negedge clk_cdr);
				period_outputs(q_before, $sformatf("glitch of %0d cycles", len));
			end
			arb_out = steady;
			for (int c = 0; c < FILT_LEN + 3; c++) begin
				@(negedge clk_cdr);
				period_outputs(q_before, $sformatf("after glitch of %0d cycles", len));
			end
		end
	endtask

	task automatic step_accumulator();
		int dir;
		// short period of 64 codes
		@(negedge clk_cdr);
		set_override(1'b1, 3);
		cur_period = codes_per_period(max_sel_of(3));
		apply_strobe(1'b0, 1'b0, 1'b1, 0, 60);
		apply_strobe(1'b1, 1'b0, 1'b0, 7, 0);
		apply_strobe(1'b0, 1'b1, 1'b0, 9, 0);
		apply_strobe(1'b1, 1'b1, 1'b0, 5, 0);
		apply_strobe(1'b1, 1'b1, 1'b1, 5, 300);
		apply_strobe(1'b1, 1'b0, 1'b1, 3, 17);
		apply_strobe(1'b0, 1'b1, 1'b1, 3, 63);
		for (int n = 0; n < N_RAND_STEPS; n++) begin
			if (n == N_RAND_STEPS / 2) begin
				// back to the arbiter period for the second half
				@(negedge clk_cdr);
				set_override(1'b0, 0);
				cur_period = codes_per_period(max_sel_of(quarter_period(arb_out)));
			end
			dir = int'($urandom % 3);
			apply_strobe(dir == 0 || dir == 2, dir == 1 || dir == 2, 1'b0,
				int'($urandom % 16), 0);
		end
	endtask

	// back-to-back loads keep two codes in the encoder pipeline
	task automatic pipelined_loads(input int q);
		int codes[$];
		int msm;
		int per;
		int n;
		@(negedge clk_cdr);
		set_override(1'b1, q);
		msm = max_sel_of(q);
		per = codes_per_period(msm);
		codes.push_back(msm * 16 + 15);
		codes.push_back(msm * 16);
		codes.push_back((msm - 1) * 16 + 6);
		codes.push_back(16 + 9);
		for (int i = 0; i < N_ENC; i++) begin
			codes.push_back(int'($urandom % per));
		end
		n = codes.size();
		for (int i = 0; i < n + 2; i++) begin
			@(negedge clk_cdr);
			if (i >= 2) begin
				compare(64'(sel), 64'(expected_sel(codes[i-2], msm)),
					$sformatf("sel for code %0d, max_sel_mux %0d", codes[i-2], msm));
			end
			load      = (i < n);
			load_code = (i < n) ? pi_pkg::CODE_W'(codes[i]) : '0;
		end
	endtask

	task automatic sel_encoding();
		pipelined_loads(31);
		pipelined_loads(12);
	endtask

	initial begin
		rstb       = 1'b0;
		arb_out    = '0;
		up         = 1'b0;
		dn         = 1'b0;
		step       = '0;
		load       = 1'b0;
		load_code  = '0;
		ext_qperi  = '0;
		exp_code   = 0;
		cur_period = 0;
		void'($urandom(18));
		repeat (16) @(negedge clk_cdr);
		reset_values();
		rstb = 1'b1;
		detect_quarter_period();
		reject_glitch();
		step_accumulator();
		sel_encoding();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: pi_ctrl_top.f
hdl/pi_pkg.sv
hdl/arb_filter.sv
hdl/phase_accum.sv
hdl/pi_local_encoder.sv
hdl/pi_ctrl_top.sv
bench/tb_pi_ctrl.sv

// File: Makefile
TOP := tb_pi_ctrl
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module pi_ctrl_top -f pi_ctrl_top.f
	verilator --lint-only --timing --top-module $(TOP) -f pi_ctrl_top.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f pi_ctrl_top.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
